//--- verilog/audio_pkg.sv
`default_nettype none

package audio_pkg;

  // Signed 16-bit PCM sample
  typedef logic signed [15:0] sample_t;

  // Left occupies the upper half
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  // Unsigned power reading
  typedef logic [10:0] level_t;

  // Meter result of 43 bits
  typedef struct packed {
    stereo_t audio;
    level_t  power;
  } meter_out_t;

endpackage

`default_nettype wire

//--- verilog/band_pkg.sv
`default_nettype none

package band_pkg;

  localparam int coef_width = 27;
  localparam int frac_bits  = 23;
  localparam int num_bands  = 6;

  // Signed Q4.23
  typedef logic signed [coef_width-1:0] fixed_t;

  // b1 = b3 = 0, b4 = b0 and the leading denominator tap is one
  typedef struct packed {
    fixed_t b0;
    fixed_t b2;
    fixed_t a1;
    fixed_t a2;
    fixed_t a3;
    fixed_t a4;
  } band_coef_t;

  localparam band_coef_t band_table [0:num_bands-1] = '{
    // 10 Hz to 100 Hz
    '{b0: 27'h0000048,
      b2: 27'h7FFFF70,
      a1: 27'h6011140,
      a2: 27'h3FCCDAA,
      a3: 27'h60330ED,
      a4: 27'h07EF029},
    // 100 Hz to 500 Hz
    '{b0: 27'h0000583,
      b2: 27'h7FFF4FA,
      a1: 27'h604CAFA,
      a2: 27'h3F1C349,
      a3: 27'h60E18C3,
      a4: 27'h07B58FB},
    // 500 Hz to 1 kHz
    '{b0: 27'h0000892,
      b2: 27'h7FFEEDB,
      a1: 27'h60676FA,
      a2: 27'h3ED4B6C,
      a3: 27'h61207B2,
      a4: 27'h07A360D},
    // 1 kHz to 5 kHz
    '{b0: 27'h001D7E8,
      b2: 27'h7FC5030,
      a1: 27'h633FA03,
      a2: 27'h271581F,
      a3: 27'h68254EA,
      a4: 27'h058658B},
    // 5 kHz to 10 kHz
    '{b0: 27'h002C477,
      b2: 27'h7FA7711,
      a1: 27'h66A9DF0,
      a2: 27'h209FEAD,
      a3: 27'h6BF5FBF,
      a4: 27'h05096DD},
    // 10 kHz to 20 kHz
    '{b0: 27'h0093EDC,
      b2: 27'h7ED8248,
      a1: 27'h7168071,
      a2: 27'h0FC755A,
      a3: 27'h770E5BC,
      a4: 27'h032F6A7}
  };

endpackage

`default_nettype wire

//--- verilog/sample_capture.sv
`timescale 1ns/1ps
`default_nettype none

module sample_capture (
  input  wire logic               aud_clk,
  input  wire logic               reset,
  input  wire logic               sample_valid,
  input  wire logic               enable,
  input  wire audio_pkg::stereo_t in_frame,
  output logic                    cap_valid,
  output logic                    cap_enable,
  output band_pkg::fixed_t        cap_x,
  output audio_pkg::stereo_t      cap_frame
);

  // Sample sits at bits 23:8 so full scale maps to 1.0
  localparam int sample_bits = $bits(audio_pkg::sample_t);
  localparam int low_pad     = band_pkg::frac_bits - (sample_bits - 1);
  localparam int high_pad    = band_pkg::coef_width - sample_bits - low_pad;

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      cap_valid  <= 1'b0;
      cap_enable <= 1'b0;
    end else begin
      cap_valid <= sample_valid;
      if (sample_valid) begin
        cap_enable <= enable;
      end
    end
  end

  always_ff @(posedge aud_clk) begin
    if (sample_valid) begin
      cap_frame <= in_frame;
      cap_x     <= {{high_pad{in_frame.left[sample_bits-1]}}, in_frame.left,
                    {low_pad{1'b0}}};
    end
  end

  // Strobes come at most every other cycle
  a_strobe_spacing: assert property (
    @(posedge aud_clk) disable iff (reset)
    sample_valid |=> !sample_valid
  ) else $error("sample_valid high on two consecutive cycles");

endmodule

`default_nettype wire

//--- verilog/iir_bandpass.sv
`timescale 1ns/1ps
`default_nettype none

module iir_bandpass #(
  parameter int band_id = 3
) (
  input  wire logic               aud_clk,
  input  wire logic               reset,
  input  wire logic               cap_valid,
  input  wire logic               cap_enable,
  input  wire band_pkg::fixed_t   cap_x,
  input  wire audio_pkg::stereo_t cap_frame,
  output logic                    filt_valid,
  output logic                    filt_enable,
  output band_pkg::fixed_t        filt_y,
  output audio_pkg::sample_t      filt_right
);

  if (band_id < 0 || band_id >= band_pkg::num_bands) begin : g_band_check
    $error("band_id %0d out of range", band_id);
  end

  localparam band_pkg::band_coef_t coef = band_pkg::band_table[band_id];

  // Q4.23 multiply keeping the low 27 bits of the shifted product
  function automatic band_pkg::fixed_t fmul(band_pkg::fixed_t a, band_pkg::fixed_t b);
    logic signed [2*band_pkg::coef_width-1:0] prod;
    prod = a * b;
    return prod[band_pkg::frac_bits +: band_pkg::coef_width];
  endfunction

  band_pkg::fixed_t z1;
  band_pkg::fixed_t z2;
  band_pkg::fixed_t z3;
  band_pkg::fixed_t z4;
  band_pkg::fixed_t y;
  band_pkg::fixed_t b0_x;
  band_pkg::fixed_t b2_x;
  band_pkg::fixed_t a1_y;
  band_pkg::fixed_t a2_y;
  band_pkg::fixed_t a3_y;
  band_pkg::fixed_t a4_y;

  assign b0_x = fmul(coef.b0, cap_x);
  assign b2_x = fmul(coef.b2, cap_x);

  // Output uses the old z1 and feeds every feedback product
  assign y = b0_x + z1;

  assign a1_y = fmul(coef.a1, y);
  assign a2_y = fmul(coef.a2, y);
  assign a3_y = fmul(coef.a3, y);
  assign a4_y = fmul(coef.a4, y);

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      z1          <= '0;
      z2          <= '0;
      z3          <= '0;
      z4          <= '0;
      filt_valid  <= 1'b0;
      filt_enable <= 1'b0;
    end else begin
      filt_valid <= cap_valid;
      if (cap_valid) begin
        filt_enable <= cap_enable;
      end
      // State is frozen through bypass samples
      if (cap_valid && cap_enable) begin
        z1 <= z2 - a1_y;
        z2 <= b2_x - a2_y + z3;
        z3 <= z4 - a3_y;
        // b4 equals b0
        z4 <= b0_x - a4_y;
      end
    end
  end

  always_ff @(posedge aud_clk) begin
    if (cap_valid) begin
      filt_right <= cap_frame.right;
      if (cap_enable) begin
        filt_y <= y;
      end else begin
        filt_y <= cap_x;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/envelope_detector.sv
`timescale 1ns/1ps
`default_nettype none

module envelope_detector #(
  parameter int smooth_shift = 6
) (
  input  wire logic               aud_clk,
  input  wire logic               reset,
  input  wire logic               filt_valid,
  input  wire logic               filt_enable,
  input  wire band_pkg::fixed_t   filt_y,
  input  wire audio_pkg::sample_t filt_right,
  output logic                    env_valid,
  output logic                    env_enable,
  output band_pkg::fixed_t        env_y,
  output audio_pkg::sample_t      env_right,
  output band_pkg::fixed_t        env_level
);

  localparam int msb = band_pkg::coef_width - 1;
  localparam band_pkg::fixed_t max_pos = {1'b0, {msb{1'b1}}};
  localparam band_pkg::fixed_t min_neg = {1'b1, {msb{1'b0}}};

  band_pkg::fixed_t mag;
  band_pkg::fixed_t acc;
  band_pkg::fixed_t diff;
  band_pkg::fixed_t acc_next;

  // Rectifier that clips the most negative input to max
  always_comb begin
    if (!filt_y[msb]) begin
      mag = filt_y;
    end else if (filt_y == min_neg) begin
      mag = max_pos;
    end else begin
      mag = -filt_y;
    end
  end

  // One-pole low-pass
  assign diff     = mag - acc;
  assign acc_next = acc + (diff >>> smooth_shift);

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      acc        <= '0;
      env_valid  <= 1'b0;
      env_enable <= 1'b0;
    end else begin
      env_valid <= filt_valid;
      if (filt_valid) begin
        env_enable <= filt_enable;
        if (filt_enable) begin
          acc <= acc_next;
        end
      end
    end
  end

  always_ff @(posedge aud_clk) begin
    if (filt_valid) begin
      env_y     <= filt_y;
      env_right <= filt_right;
    end
  end

  assign env_level = acc;

  a_level_positive: assert property (
    @(posedge aud_clk) disable iff (reset)
    !env_level[msb]
  ) else $error("env_level went negative: %h", env_level);

endmodule

`default_nettype wire

//--- verilog/level_output.sv
`timescale 1ns/1ps
`default_nettype none

module level_output (
  input  wire logic               aud_clk,
  input  wire logic               reset,
  input  wire logic               env_valid,
  input  wire logic               env_enable,
  input  wire band_pkg::fixed_t   env_y,
  input  wire audio_pkg::sample_t env_right,
  input  wire band_pkg::fixed_t   env_level,
  output logic                    out_valid,
  output audio_pkg::meter_out_t   out_meter
);

  localparam int msb         = band_pkg::coef_width - 1;
  localparam int top_bit     = band_pkg::frac_bits;
  localparam int sample_bits = $bits(audio_pkg::sample_t);
  localparam int level_bits  = $bits(audio_pkg::level_t);

  localparam audio_pkg::sample_t sat_pos = {1'b0, {(sample_bits-1){1'b1}}};
  localparam audio_pkg::sample_t sat_neg = {1'b1, {(sample_bits-1){1'b0}}};

  logic                  in_range;
  audio_pkg::sample_t    sat_left;
  audio_pkg::meter_out_t meter_next;

  // Bits above 23 must all copy the sign of bit 23
  assign in_range = (env_y[msb:top_bit] == {(msb-top_bit+1){env_y[top_bit]}});

  always_comb begin
    if (in_range) begin
      sat_left = env_y[top_bit -: sample_bits];
    end else if (env_y[msb]) begin
      sat_left = sat_neg;
    end else begin
      sat_left = sat_pos;
    end
  end

  always_comb begin
    meter_next.audio.right = env_right;
    if (env_enable) begin
      meter_next.audio.left = sat_left;
      meter_next.power      = env_level[top_bit -: level_bits];
    end else begin
      // Bypass word is the input widened, so this is exact
      meter_next.audio.left = env_y[top_bit -: sample_bits];
      meter_next.power      = '0;
    end
  end

  always_ff @(posedge aud_clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_meter <= '0;
    end else begin
      out_valid <= env_valid;
      if (env_valid) begin
        out_meter <= meter_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/band_meter_top.sv
`timescale 1ns/1ps
`default_nettype none

module band_meter_top #(
  parameter int band_id      = 3,
  parameter int smooth_shift = 6
) (
  input  wire logic               aud_clk,
  input  wire logic               reset,
  input  wire logic               sample_valid,
  input  wire logic               enable,
  input  wire audio_pkg::stereo_t in_frame,
  output logic                    out_valid,
  output audio_pkg::meter_out_t   out_meter
);

  logic               cap_valid;
  logic               cap_enable;
  band_pkg::fixed_t   cap_x;
  audio_pkg::stereo_t cap_frame;

  logic               filt_valid;
  logic               filt_enable;
  band_pkg::fixed_t   filt_y;
  audio_pkg::sample_t filt_right;

  logic               env_valid;
  logic               env_enable;
  band_pkg::fixed_t   env_y;
  audio_pkg::sample_t env_right;
  band_pkg::fixed_t   env_level;

  sample_capture capture0 (
    .aud_clk      (aud_clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .enable       (enable),
    .in_frame     (in_frame),
    .cap_valid    (cap_valid),
    .cap_enable   (cap_enable),
    .cap_x        (cap_x),
    .cap_frame    (cap_frame)
  );

  iir_bandpass #(
    .band_id (band_id)
  ) filter0 (
    .aud_clk     (aud_clk),
    .reset       (reset),
    .cap_valid   (cap_valid),
    .cap_enable  (cap_enable),
    .cap_x       (cap_x),
    .cap_frame   (cap_frame),
    .filt_valid  (filt_valid),
    .filt_enable (filt_enable),
    .filt_y      (filt_y),
    .filt_right  (filt_right)
  );

  envelope_detector #(
    .smooth_shift (smooth_shift)
  ) envelope0 (
    .aud_clk     (aud_clk),
    .reset       (reset),
    .filt_valid  (filt_valid),
    .filt_enable (filt_enable),
    .filt_y      (filt_y),
    .filt_right  (filt_right),
    .env_valid   (env_valid),
    .env_enable  (env_enable),
    .env_y       (env_y),
    .env_right   (env_right),
    .env_level   (env_level)
  );

  level_output output0 (
    .aud_clk    (aud_clk),
    .reset      (reset),
    .env_valid  (env_valid),
    .env_enable (env_enable),
    .env_y      (env_y),
    .env_right  (env_right),
    .env_level  (env_level),
    .out_valid  (out_valid),
    .out_meter  (out_meter)
  );

endmodule

`default_nettype wire

//--- test/band_meter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module band_meter_tb;

  localparam int band_id      = 3;
  localparam int smooth_shift = 6;
  localparam int max_cases    = 64;

  logic                  aud_clk;
  logic                  reset;
  logic                  sample_valid;
  logic                  enable;
  audio_pkg::stereo_t    in_frame;
  logic                  out_valid;
  audio_pkg::meter_out_t out_meter;

  // Case table
  logic                  case_en [max_cases];
  audio_pkg::stereo_t    case_in [max_cases];
  int                    case_gap [max_cases];
  int                    case_src [max_cases];
  audio_pkg::stereo_t    case_exp [max_cases];
  audio_pkg::level_t     case_pow [max_cases];
  int                    num_cases;

  audio_pkg::stereo_t    exp_audio_q [$];
  audio_pkg::level_t     exp_power_q [$];
  int                    issue_q [$];
  bit                    rising_q [$];

  int                    cycle;
  int                    timeout_limit;
  int                    value_errors;
  int                    timing_errors;
  bit                    have_prev_power;
  audio_pkg::level_t     prev_power;

  // Reference state
  longint                mz1;
  longint                mz2;
  longint                mz3;
  longint                mz4;
  longint                macc;

  localparam band_pkg::band_coef_t coef = band_pkg::band_table[band_id];

  band_meter_top #(
    .band_id      (band_id),
    .smooth_shift (smooth_shift)
  ) dut0 (
    .aud_clk      (aud_clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .enable       (enable),
    .in_frame     (in_frame),
    .out_valid    (out_valid),
    .out_meter    (out_meter)
  );

  initial begin
    aud_clk = 1'b0;
    forever #4 aud_clk = ~aud_clk;
  end

  function automatic longint to_long(band_pkg::fixed_t v);
    return longint'(v);
  endfunction

  // Two's complement wrap to 27 bits
  function automatic longint wrap27(longint v);
    longint m;
    m = v & ((64'sd1 <<< 27) - 1);
    if (m >= (64'sd1 <<< 26)) begin
      m = m - (64'sd1 <<< 27);
    end
    return m;
  endfunction

  function automatic longint qmul(longint a, longint b);
    return wrap27((a * b) >>> 23);
  endfunction

  task automatic model_step(input logic en, input audio_pkg::stereo_t frame,
                            output audio_pkg::stereo_t exp_audio,
                            output audio_pkg::level_t exp_power);
    longint x;
    longint y;
    longint mag;
    longint b0x;
    longint b2x;
    x = longint'(frame.left) * 256;
    exp_audio.right = frame.right;
    if (!en) begin
      exp_audio.left = frame.left;
      exp_power = '0;
    end else begin
      b0x = qmul(to_long(coef.b0), x);
      b2x = qmul(to_long(coef.b2), x);
      y = wrap27(b0x + mz1);
      mz1 = wrap27(mz2 - qmul(to_long(coef.a1), y));
      mz2 = wrap27(b2x - qmul(to_long(coef.a2), y) + mz3);
      mz3 = wrap27(mz4 - qmul(to_long(coef.a3), y));
      mz4 = wrap27(b0x - qmul(to_long(coef.a4), y));
      if (y == -(64'sd1 <<< 26)) begin
        mag = (64'sd1 <<< 26) - 1;
      end else if (y < 0) begin
        mag = -y;
      end else begin
        mag = y;
      end
      macc = wrap27(macc + ((mag - macc) >>> smooth_shift));
      if (y > 64'sd8388607) begin
        exp_audio.left = 16'h7fff;
      end else if (y < -64'sd8388608) begin
        exp_audio.left = 16'h8000;
      end else begin
        exp_audio.left = audio_pkg::sample_t'(y >>> 8);
      end
      exp_power = audio_pkg::level_t'(macc >>> 13);
    end
  endtask

  task automatic check_stereo(input string name, input audio_pkg::stereo_t got,
                              input audio_pkg::stereo_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_level(input string name, input audio_pkg::level_t got,
                             input audio_pkg::level_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    int    code;
    string line;
    logic [15:0] f_en;
    logic [15:0] f_l;
    logic [15:0] f_r;
    logic [15:0] f_gap;
    logic [15:0] f_src;
    logic [15:0] f_el;
    logic [15:0] f_er;
    logic [15:0] f_ep;
    num_cases = 0;
    fd = $fopen("test/band_meter_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file");
    end else begin
      while (!$feof(fd) && num_cases < max_cases) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      f_en, f_l, f_r, f_gap, f_src, f_el, f_er, f_ep);
          if (n == 8) begin
            case_en[num_cases]        = f_en[0];
            case_in[num_cases].left   = f_l;
            case_in[num_cases].right  = f_r;
            case_gap[num_cases]       = (f_gap < 2) ? 2 : f_gap;
            case_src[num_cases]       = f_src;
            case_exp[num_cases].left  = f_el;
            case_exp[num_cases].right = f_er;
            case_pow[num_cases]       = f_ep[10:0];
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  always @(posedge aud_clk) begin
    cycle <= cycle + 1;
  end

  // Watchdog on the cycle count
  initial begin
    wait (timeout_limit > 0);
    while (cycle <= timeout_limit) begin
      @(posedge aud_clk);
    end
    $display("timeout: run passed %0d cycles with outputs still pending", timeout_limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // Output monitor sampled away from the active edge
  always @(negedge aud_clk) begin
    if (!reset) begin
      if (issue_q.size() > 0 && issue_q[0] + 4 < cycle) begin
        $display("no out_valid 4 cycles after the sample issued in cycle %0d", issue_q[0]);
        timing_errors++;
        void'(issue_q.pop_front());
        void'(exp_audio_q.pop_front());
        void'(exp_power_q.pop_front());
        void'(rising_q.pop_front());
      end
      if (out_valid === 1'b1) begin
        if (issue_q.size() == 0) begin
          $display("out_valid seen in cycle %0d with no sample in flight", cycle);
          timing_errors++;
        end else begin
          if (issue_q[0] + 4 != cycle) begin
            $display("out_valid in cycle %0d for a sample issued in cycle %0d",
                     cycle, issue_q[0]);
            timing_errors++;
          end
          check_stereo("out_meter.audio", out_meter.audio, exp_audio_q[0]);
          check_level("out_meter.power", out_meter.power, exp_power_q[0]);
          if (rising_q[0]) begin
            if (have_prev_power && out_meter.power < prev_power) begin
              $display("power fell during the square wave, from %0d to %0d",
                       prev_power, out_meter.power);
              value_errors++;
            end
            have_prev_power = 1'b1;
            prev_power = out_meter.power;
          end
          void'(issue_q.pop_front());
          void'(exp_audio_q.pop_front());
          void'(exp_power_q.pop_front());
          void'(rising_q.pop_front());
        end
      end
    end
  end

  initial begin
    audio_pkg::stereo_t exp_audio;
    audio_pkg::level_t  exp_power;
    reset           = 1'b1;
    sample_valid    = 1'b0;
    enable          = 1'b0;
    in_frame        = '0;
    cycle           = 0;
    timeout_limit   = 0;
    value_errors    = 0;
    timing_errors   = 0;
    have_prev_power = 1'b0;
    prev_power      = '0;
    mz1             = 0;
    mz2             = 0;
    mz3             = 0;
    mz4             = 0;
    macc            = 0;
    load_cases();
    timeout_limit = num_cases * 4 + 40;
    repeat (4) @(posedge aud_clk);
    #1 reset = 1'b0;
    @(negedge aud_clk);
    if (out_valid !== 1'b0) begin
      $display("out_valid not low after reset");
      timing_errors++;
    end
    check_stereo("out_meter.audio", out_meter.audio, '0);
    check_level("out_meter.power", out_meter.power, '0);
    for (int i = 0; i < num_cases; i++) begin
      @(posedge aud_clk);
      #1;
      sample_valid = 1'b1;
      enable       = case_en[i];
      in_frame     = case_in[i];
      model_step(case_en[i], case_in[i], exp_audio, exp_power);
      if (case_src[i] == 0) begin
        exp_audio = case_exp[i];
        exp_power = case_pow[i];
      end
      exp_audio_q.push_back(exp_audio);
      exp_power_q.push_back(exp_power);
      rising_q.push_back(case_src[i] == 2);
      issue_q.push_back(cycle);
      @(posedge aud_clk);
      #1 sample_valid = 1'b0;
      repeat (case_gap[i] - 2) @(posedge aud_clk);
    end
    while (issue_q.size() > 0) begin
      @(posedge aud_clk);
    end
    repeat (6) @(posedge aud_clk);
    $display("errors: %0d value, %0d timing over %0d cases",
             value_errors, timing_errors, num_cases);
    if (value_errors == 0 && timing_errors == 0 && num_cases > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- audio_band_meter.f
verilog/audio_pkg.sv
verilog/band_pkg.sv
verilog/sample_capture.sv
verilog/iir_bandpass.sv
verilog/envelope_detector.sv
verilog/level_output.sv
verilog/band_meter_top.sv
test/band_meter_tb.sv

//--- test/band_meter_cases.txt
# enable left right gap src exp_left exp_right exp_power (all hex)
# src 0 compares with the listed values, 1 with the model, 2 with the model and a rising power
0 1234 abcd 4 0 1234 abcd 000
0 8000 7fff 4 0 8000 7fff 000
0 ffff 0001 4 0 ffff 0001 000
1 4000 0000 4 0 00eb 0000 000
1 0000 0101 4 1 0000 0000 000
1 0000 0202 4 1 0000 0000 000
1 0000 0303 4 1 0000 0000 000
1 0000 0404 4 1 0000 0000 000
1 0000 0505 4 1 0000 0000 000
1 7fff 2222 4 2 0000 0000 000
1 7fff 2223 4 1 0000 0000 000
1 7fff 2224 4 1 0000 0000 000
1 7fff 2225 4 1 0000 0000 000
1 7fff 2226 4 1 0000 0000 000
1 7fff 2227 4 1 0000 0000 000
1 8000 2228 4 1 0000 0000 000
1 8000 2229 4 1 0000 0000 000
1 8000 222a 4 1 0000 0000 000
1 8000 222b 4 1 0000 0000 000
1 8000 222c 4 1 0000 0000 000
1 8000 222d 4 2 0000 0000 000
0 5a5a 3c3c 4 0 5a5a 3c3c 000
0 a5a5 c3c3 4 0 a5a5 c3c3 000
1 7fff 4444 4 1 0000 0000 000
1 7fff 4445 4 1 0000 0000 000
1 8000 4446 4 1 0000 0000 000
1 8000 0f0f 2 1 0000 0000 000
1 7fff 0e0e 2 1 0000 0000 000
0 1111 2222 2 0 1111 2222 000
1 8000 0d0d 2 1 0000 0000 000
1 0000 0c0c 4 1 0000 0000 000
0 0000 0000 4 0 0000 0000 000
